// ==== hw/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// alu operation codes
`define ALU_NONE     5'd0
`define ALU_ADD      5'd1
`define ALU_SUB      5'd2
`define ALU_XOR      5'd3
`define ALU_OR       5'd4
`define ALU_AND      5'd5
`define ALU_SLL      5'd6
`define ALU_SRL      5'd7
`define ALU_SRA      5'd8
`define ALU_SLT      5'd9
`define ALU_SLTU     5'd10
`define ALU_RETURN_A 5'd11
`define ALU_RETURN_B 5'd12

// write-back sources
`define WB_ALU       3'b000
`define WB_LOAD      3'b001
`define WB_LINK      3'b010
`define WB_ALU32     3'b100 // alu result, sign-extended from bit 31

`define SEL_PC       2'b00 // operand a
`define SEL_RS1      2'b01
`define SEL_IMM      2'b00 // operand b
`define SEL_RS2      2'b01

`define RESET_PC     64'h0

`endif

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    typedef logic [63:0] xlen_t;     // data word

    typedef logic [31:0] inst_t;

    typedef logic [4:0]  regIdx_t;

    typedef logic [4:0]  aluOp_t;

    typedef logic [2:0]  wbSel_t;

    typedef logic [1:0]  opSel_t;

    typedef logic [7:0]  byteMask_t; // one bit per byte lane

    typedef logic [3:0]  readSize_t; // load width in bytes

endpackage

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module decoder (
    input  rv_pkg::inst_t     inst,
    input  rv_pkg::xlen_t     rs1,
    input  rv_pkg::xlen_t     rs2,
    output rv_pkg::aluOp_t    aluOperate,
    output rv_pkg::opSel_t    selA,
    output rv_pkg::opSel_t    selB,
    output rv_pkg::byteMask_t memoryWriteMask,
    output logic              writeRD,
    output logic              pcSel,
    output logic              npcOp,
    output rv_pkg::wbSel_t    writeBackDataSelect,
    output logic              memoryReadWen,
    output logic              sext,
    output rv_pkg::readSize_t readNum,
    output logic              rs1to32
);

    logic [6:0] opCode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       illegal;

    assign opCode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        aluOperate          = `ALU_NONE;
        selA                = `SEL_RS1;
        selB                = `SEL_IMM;
        memoryWriteMask     = '0;
        writeRD             = 1'b0;
        pcSel               = 1'b0;
        npcOp               = 1'b0;
        writeBackDataSelect = `WB_ALU;
        memoryReadWen       = 1'b0;
        sext                = 1'b0;
        readNum             = '0;
        rs1to32             = 1'b0;
        illegal             = 1'b0;
        case (opCode)
            7'b0110011: begin // R-type
                selB    = `SEL_RS2;
                writeRD = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: aluOperate = `ALU_ADD;
                    10'b0100000_000: aluOperate = `ALU_SUB;
                    10'b0000000_001: aluOperate = `ALU_SLL;
                    10'b0000000_010: aluOperate = `ALU_SLT;
                    10'b0000000_011: aluOperate = `ALU_SLTU;
                    10'b0000000_100: aluOperate = `ALU_XOR;
                    10'b0000000_101: aluOperate = `ALU_SRL;
                    10'b0100000_101: aluOperate = `ALU_SRA;
                    10'b0000000_110: aluOperate = `ALU_OR;
                    10'b0000000_111: aluOperate = `ALU_AND;
                    default:         illegal    = 1'b1;
                endcase
            end
            7'b0010011: begin // I-type alu
                writeRD = 1'b1;
                case (funct3)
                    3'b000:  aluOperate = `ALU_ADD;
                    3'b010:  aluOperate = `ALU_SLT;
                    3'b011:  aluOperate = `ALU_SLTU;
                    3'b100:  aluOperate = `ALU_XOR;
                    3'b110:  aluOperate = `ALU_OR;
                    3'b111:  aluOperate = `ALU_AND;
                    3'b001: begin
                        aluOperate = `ALU_SLL;
                        illegal    = (funct7[6:1] != 6'h0);
                    end
                    default: begin // srli / srai, bit 25 is shamt[5]
                        case (funct7[6:1])
                            6'h00:   aluOperate = `ALU_SRL;
                            6'h10:   aluOperate = `ALU_SRA;
                            default: illegal    = 1'b1;
                        endcase
                    end
                endcase
            end
            7'b0111011: begin // R-type word forms
                selB                = `SEL_RS2;
                writeRD             = 1'b1;
                writeBackDataSelect = `WB_ALU32;
                rs1to32             = (funct3 == 3'b101);
                case ({funct7, funct3})
                    10'b0000000_000: aluOperate = `ALU_ADD;
                    10'b0100000_000: aluOperate = `ALU_SUB;
                    10'b0000000_001: aluOperate = `ALU_SLL;
                    10'b0000000_101: aluOperate = `ALU_SRL;
                    10'b0100000_101: aluOperate = `ALU_SRA;
                    default:         illegal    = 1'b1;
                endcase
            end
            7'b0011011: begin // I-type word forms
                writeRD             = 1'b1;
                writeBackDataSelect = `WB_ALU32;
                rs1to32             = (funct3 == 3'b101);
                case ({funct7, funct3})
                    10'b0000000_001: aluOperate = `ALU_SLL;
                    10'b0000000_101: aluOperate = `ALU_SRL;
                    10'b0100000_101: aluOperate = `ALU_SRA;
                    default: begin
                        aluOperate = `ALU_ADD;
                        illegal    = (funct3 != 3'b000);
                    end
                endcase
            end
            7'b0110111: begin // lui
                writeRD    = 1'b1;
                aluOperate = `ALU_RETURN_B;
            end
            7'b0010111: begin // auipc
                selA       = `SEL_PC;
                writeRD    = 1'b1;
                aluOperate = `ALU_ADD;
            end
            7'b0000011: begin // loads, address is rs1 + imm
                writeRD             = 1'b1;
                memoryReadWen       = 1'b1;
                writeBackDataSelect = `WB_LOAD;
                aluOperate          = `ALU_ADD;
                sext                = ~funct3[2];
                readNum             = 4'd1 << funct3[1:0];
                illegal             = (funct3 == 3'b111);
            end
            7'b0100011: begin // stores
                aluOperate      = `ALU_ADD;
                memoryWriteMask = 8'hff >> (4'd8 - (4'd1 << funct3[1:0]));
                illegal         = funct3[2];
            end
            7'b1101111: begin // jal
                writeRD             = 1'b1;
                npcOp               = 1'b1;
                writeBackDataSelect = `WB_LINK;
            end
            7'b1100111: begin // jalr
                writeRD             = 1'b1;
                pcSel               = 1'b1;
                npcOp               = 1'b1;
                writeBackDataSelect = `WB_LINK;
                illegal             = (funct3 != 3'b000);
            end
            7'b1100011: begin // branches
                case (funct3)
                    3'b000:  npcOp = (rs1 == rs2);
                    3'b001:  npcOp = (rs1 != rs2);
                    3'b100:  npcOp = ($signed(rs1) < $signed(rs2));
                    3'b101:  npcOp = ($signed(rs1) >= $signed(rs2));
                    3'b110:  npcOp = (rs1 < rs2);
                    3'b111:  npcOp = (rs1 >= rs2);
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin // unknown encodings change no state
            writeRD         = 1'b0;
            npcOp           = 1'b0;
            memoryWriteMask = '0;
            memoryReadWen   = 1'b0;
        end
        if (inst[11:7] == 5'd0) begin
            writeRD = 1'b0; // x0
        end
    end

endmodule

// ==== hw/immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  rv_pkg::inst_t inst,
    output rv_pkg::xlen_t imm
);

    logic [6:0] opCode;

    assign opCode = inst[6:0];

    always_comb begin
        case (opCode)
            7'b0010011, 7'b0011011, 7'b0000011, 7'b1100111: begin // I
                imm = {{52{inst[31]}}, inst[31:20]};
            end
            7'b0100011: begin // S
                imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            end
            7'b1100011: begin // B
                imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            7'b0110111, 7'b0010111: begin // U
                imm = {{32{inst[31]}}, inst[31:12], 12'h0};
            end
            7'b1101111: begin // J
                imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu (
    input  rv_pkg::xlen_t  a,
    input  rv_pkg::xlen_t  b,
    input  rv_pkg::aluOp_t aluOperate,
    input  logic           rs1to32,
    output rv_pkg::xlen_t  res
);

    rv_pkg::xlen_t aShift;
    logic [5:0]    shamt;

    // word right shifts see only the low half of rs1
    always_comb begin
        aShift = a;
        shamt  = b[5:0];
        if (rs1to32) begin
            shamt = {1'b0, b[4:0]};
            if (aluOperate == `ALU_SRA) begin
                aShift = {{32{a[31]}}, a[31:0]};
            end else begin
                aShift = {32'h0, a[31:0]};
            end
        end
    end

    always_comb begin
        case (aluOperate)
            `ALU_ADD:      res = a + b;
            `ALU_SUB:      res = a - b;
            `ALU_XOR:      res = a ^ b;
            `ALU_OR:       res = a | b;
            `ALU_AND:      res = a & b;
            `ALU_SLL:      res = aShift << shamt;
            `ALU_SRL:      res = aShift >> shamt;
            `ALU_SRA:      res = $signed(aShift) >>> shamt;
            `ALU_SLT:      res = {63'h0, $signed(a) < $signed(b)};
            `ALU_SLTU:     res = {63'h0, a < b};
            `ALU_RETURN_A: res = a;
            `ALU_RETURN_B: res = b;
            default:       res = '0; // ALU_NONE
        endcase
    end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  rv_pkg::regIdx_t raddr1,
    input  rv_pkg::regIdx_t raddr2,
    input  logic            wen,
    input  rv_pkg::regIdx_t waddr,
    input  rv_pkg::xlen_t   wdata,
    output rv_pkg::xlen_t   rdata1,
    output rv_pkg::xlen_t   rdata2
);

    rv_pkg::xlen_t regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// ==== hw/loadStore.sv ====
`timescale 1ns/1ps

module loadStore (
    input  logic [2:0]        addr,
    input  rv_pkg::xlen_t     storeData,
    input  rv_pkg::byteMask_t memoryWriteMask,
    input  rv_pkg::readSize_t readNum,
    input  logic              sext,
    input  rv_pkg::xlen_t     rdataRaw,
    output rv_pkg::xlen_t     wdata,
    output rv_pkg::byteMask_t wmask,
    output rv_pkg::xlen_t     loadData
);

    logic [5:0]    bitOffset;
    rv_pkg::xlen_t lane;

    assign bitOffset = {addr, 3'b000};

    // stores move into their byte lanes
    assign wmask = memoryWriteMask << addr;
    assign wdata = storeData << bitOffset;

    assign lane = rdataRaw >> bitOffset; // addressed byte lands at bit 0

    always_comb begin
        case (readNum)
            4'd1: begin
                loadData = {{56{sext & lane[7]}}, lane[7:0]};
            end
            4'd2: begin
                loadData = {{48{sext & lane[15]}}, lane[15:0]};
            end
            4'd4: begin
                loadData = {{32{sext & lane[31]}}, lane[31:0]};
            end
            4'd8: begin
                loadData = lane;
            end
            default: begin
                loadData = '0;
            end
        endcase
    end

endmodule

// ==== hw/pcUnit.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module pcUnit (
    input  logic          clk,
    input  logic          rstN,
    input  logic          npcOp,
    input  logic          pcSel,
    input  rv_pkg::xlen_t rs1,
    input  rv_pkg::xlen_t imm,
    output rv_pkg::xlen_t pc
);

    rv_pkg::xlen_t sum;
    rv_pkg::xlen_t nextPc;

    assign sum = (pcSel ? rs1 : pc) + imm; // jalr bases on rs1

    always_comb begin
        nextPc = pc + 64'd4;
        if (npcOp) begin
            nextPc = pcSel ? {sum[63:1], 1'b0} : sum;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== hw/rvCore.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvCore (
    input  logic              clk,
    input  logic              rstN,
    output rv_pkg::xlen_t     instAddr,
    input  rv_pkg::inst_t     inst,
    output rv_pkg::xlen_t     dataAddr,
    output rv_pkg::xlen_t     dataWdata,
    output rv_pkg::byteMask_t dataWmask,
    output logic              dataRen,
    input  rv_pkg::xlen_t     dataRdata,
    output logic              retireValid,
    output rv_pkg::regIdx_t   retireRd,
    output rv_pkg::xlen_t     retireValue
);

    rv_pkg::xlen_t     pc, imm, rs1Data, rs2Data, opA, opB, aluRes, loadData, wbData;
    rv_pkg::regIdx_t   rs1Idx, rs2Idx, rdIdx;
    rv_pkg::aluOp_t    aluOperate;
    rv_pkg::opSel_t    selA, selB;
    rv_pkg::byteMask_t memoryWriteMask;
    rv_pkg::wbSel_t    writeBackDataSelect;
    rv_pkg::readSize_t readNum;
    logic              writeRD, pcSel, npcOp, memoryReadWen, sext, rs1to32;

    assign rs1Idx = inst[19:15];
    assign rs2Idx = inst[24:20];
    assign rdIdx  = inst[11:7];

    assign opA = (selA == `SEL_PC) ? pc : rs1Data;
    assign opB = (selB == `SEL_RS2) ? rs2Data : imm;

    always_comb begin
        case (writeBackDataSelect)
            `WB_LOAD:  wbData = loadData;
            `WB_LINK:  wbData = pc + 64'd4;
            `WB_ALU32: wbData = {{32{aluRes[31]}}, aluRes[31:0]};
            default:   wbData = aluRes;
        endcase
    end

    decoder decoder0 (
        .inst(inst), .rs1(rs1Data), .rs2(rs2Data),
        .aluOperate(aluOperate), .selA(selA), .selB(selB),
        .memoryWriteMask(memoryWriteMask), .writeRD(writeRD),
        .pcSel(pcSel), .npcOp(npcOp), .writeBackDataSelect(writeBackDataSelect),
        .memoryReadWen(memoryReadWen), .sext(sext), .readNum(readNum), .rs1to32(rs1to32)
    );

    immGen immGen0 (.inst(inst), .imm(imm));

    alu alu0 (.a(opA), .b(opB), .aluOperate(aluOperate), .rs1to32(rs1to32), .res(aluRes));

    regFile regFile0 (
        .clk(clk), .rstN(rstN), .raddr1(rs1Idx), .raddr2(rs2Idx),
        .wen(writeRD), .waddr(rdIdx), .wdata(wbData),
        .rdata1(rs1Data), .rdata2(rs2Data)
    );

    loadStore loadStore0 (
        .addr(aluRes[2:0]), .storeData(rs2Data), .memoryWriteMask(memoryWriteMask),
        .readNum(readNum), .sext(sext), .rdataRaw(dataRdata),
        .wdata(dataWdata), .wmask(dataWmask), .loadData(loadData)
    );

    pcUnit pcUnit0 (
        .clk(clk), .rstN(rstN), .npcOp(npcOp), .pcSel(pcSel),
        .rs1(rs1Data), .imm(imm), .pc(pc)
    );

    assign instAddr    = pc;
    assign dataAddr    = aluRes;
    assign dataRen     = memoryReadWen;
    assign retireValid = writeRD; // mirrors the register write port
    assign retireRd    = rdIdx;
    assign retireValue = wbData;

endmodule

// ==== test/rvCore_sva.sv ====
`timescale 1ns/1ps

module rvCore_sva (
    input logic              clk,
    input logic              rstN,
    input rv_pkg::inst_t     inst,
    input rv_pkg::xlen_t     instAddr,
    input rv_pkg::byteMask_t dataWmask,
    input logic              dataRen,
    input logic              retireValid,
    input rv_pkg::regIdx_t   retireRd
);

    noX0Retire: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> retireRd != 5'd0)
        else $error("retire reported a write to x0");

    maskOnlyOnStore: assert property (@(posedge clk) disable iff (!rstN)
        inst[6:0] != 7'b0100011 |-> dataWmask == 8'h0) // store opcode
        else $error("byte mask active outside a store");

    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        instAddr[1:0] == 2'b00)
        else $error("instAddr not word aligned");

    noReadWithWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(dataRen && dataWmask != 8'h0))
        else $error("data read and write in the same cycle");

endmodule

bind rvCore rvCore_sva sva0 (
    .clk(clk), .rstN(rstN), .inst(inst), .instAddr(instAddr), .dataWmask(dataWmask),
    .dataRen(dataRen), .retireValid(retireValid), .retireRd(retireRd)
);

// ==== test/rvCore_tb.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rvCore_tb;

    logic              clk = 1'b0;
    logic              rstN = 1'b0;
    rv_pkg::inst_t     inst = 32'h0000_0013; // addi x0, x0, 0
    rv_pkg::xlen_t     instAddr, dataAddr, dataWdata, dataRdata, retireValue;
    rv_pkg::byteMask_t dataWmask;
    rv_pkg::regIdx_t   retireRd;
    logic              dataRen, retireValid;

    logic [31:0] progInst [64];
    logic        expValid [64];
    logic        expRen [64];
    logic [4:0]  expRd [64];
    logic [63:0] expValue [64], expWdata [64], expNpc [64], expAddr [64];
    logic [7:0]  expMask [64];
    int          rowTest [64];
    logic [63:0] shadowRegs [32];
    logic [63:0] shadowMem [32];
    logic [63:0] dataMem [32];
    int          nRows = 0, buildTest = 1, curTest = 1, row = 0, cycles = 0;
    int          checkCount = 0, failCount = 0;
    int          testErr [1:6] = '{default: 0};
    string       testName [1:6] = '{"reset, addi, lui, auipc", "alu and word ops",
                                    "stores with readback", "load extension",
                                    "branches", "jal and jalr"};

    rvCore dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                dataMem[i] <= fillWord(i);
            end
        end else begin
            for (int b = 0; b < 8; b++) begin
                if (dataWmask[b]) begin
                    dataMem[dataAddr[7:3]][8*b +: 8] <= dataWdata[8*b +: 8];
                end
            end
        end
    end

    assign dataRdata = rstN ? dataMem[dataAddr[7:3]] : 64'd0;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > nRows + 4 + 20) begin // rows + reset + slack
            $display("timeout: program did not run to its end within %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [63:0] fillWord(input int i);
        logic [31:0] s;
        logic [31:0] hi;
        s = 32'h85c7;
        hi = 32'h0;
        for (int k = 0; k <= i; k++) begin
            s = xorshift(s);
            hi = s;
            s = xorshift(s);
        end
        return {hi, s};
    endfunction

    function automatic logic [63:0] rowPc(input int r);
        return 64'(r) << 2;
    endfunction

    function automatic logic [63:0] sx32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] encR(input int f7, rs2, rs1, f3, rd, op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encI(input int imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encS(input int imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input int imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encU(input int imm, rd, op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encJ(input int imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // funct3 picks width and extension
    function automatic logic [63:0] loadModel(input logic [63:0] addr, input int f3);
        logic [63:0] w;
        w = shadowMem[addr[7:3]] >> {addr[2:0], 3'b000};
        case (f3)
            0: return {{56{w[7]}}, w[7:0]};
            1: return {{48{w[15]}}, w[15:0]};
            2: return {{32{w[31]}}, w[31:0]};
            4: return {56'h0, w[7:0]};
            5: return {48'h0, w[15:0]};
            6: return {32'h0, w[31:0]};
            default: return w;
        endcase
    endfunction

    task automatic addRow(input logic [31:0] in, input int rd, input logic [63:0] val,
                          input logic [7:0] mask, input logic [63:0] wd, input int skip);
        progInst[nRows] = in;
        expValid[nRows] = (rd != 0);
        expRd[nRows] = 5'(rd);
        expValue[nRows] = val;
        expMask[nRows] = mask;
        expWdata[nRows] = wd;
        expRen[nRows] = 1'b0;
        expAddr[nRows] = 64'd0;
        expNpc[nRows] = rowPc(nRows + 1 + skip);
        rowTest[nRows] = buildTest;
        if (rd != 0) begin
            shadowRegs[rd] = val;
        end
        nRows++;
    endtask

    task automatic addAlu(input logic [31:0] in, input int rd, input logic [63:0] val);
        addRow(in, rd, val, 8'h0, 64'd0, 0);
    endtask

    task automatic addPoison(); // skipped over, never retires
        addRow(encI(-1, 0, 0, 31, 'h13), 31, '1, 8'h0, 64'd0, 0);
    endtask

    task automatic addStore(input int f3, rs2, rs1, off);
        logic [63:0] addr;
        logic [63:0] wd;
        logic [7:0]  m;
        addr = shadowRegs[rs1] + 64'(off);
        m = 8'((16'd1 << (1 << f3)) - 16'd1);
        m = m << addr[2:0];
        wd = shadowRegs[rs2] << {addr[2:0], 3'b000};
        for (int b = 0; b < 8; b++) begin
            if (m[b]) begin
                shadowMem[addr[7:3]][8*b +: 8] = wd[8*b +: 8];
            end
        end
        addRow(encS(off, rs2, rs1, f3), 0, 64'd0, m, wd, 0);
        expAddr[nRows - 1] = addr;
    endtask

    task automatic addLoad(input int f3, rd, rs1, off);
        logic [63:0] addr;
        addr = shadowRegs[rs1] + 64'(off);
        addAlu(encI(off, rs1, f3, rd, 'h03), rd, loadModel(addr, f3));
        expRen[nRows - 1] = 1'b1;
        expAddr[nRows - 1] = addr;
    endtask

    // not taken first, then taken over a skipped row
    task automatic addBranches(input int f3, tA, tB, nA, nB);
        addRow(encB(8, nB, nA, f3), 0, 64'd0, 8'h0, 64'd0, 0);
        addRow(encB(8, tB, tA, f3), 0, 64'd0, 8'h0, 64'd0, 1);
        addPoison();
    endtask

    task automatic buildProgram();
        for (int i = 0; i < 32; i++) begin
            shadowRegs[i] = 64'd0;
            shadowMem[i] = fillWord(i);
        end
        addAlu(encI(-5, 0, 0, 1, 'h13), 1, 64'hffff_ffff_ffff_fffb);
        addAlu(encU('h80000, 2, 'h37), 2, 64'hffff_ffff_8000_0000);
        addAlu(encU(1, 3, 'h17), 3, rowPc(nRows) + 64'h1000);
        addAlu(encI(100, 0, 0, 4, 'h13), 4, 64'd100);
        addAlu(encI(1, 0, 0, 7, 'h13), 7, 64'd1);
        buildTest = 2;
        addAlu(encR('h20, 1, 4, 0, 5, 'h33), 5, shadowRegs[4] - shadowRegs[1]);
        addAlu(encR('h20, 4, 2, 5, 6, 'h33), 6, $signed(shadowRegs[2]) >>> shadowRegs[4][5:0]);
        addAlu(encR(0, 4, 1, 2, 8, 'h33), 8, {63'd0, $signed(shadowRegs[1]) < $signed(shadowRegs[4])});
        addAlu(encR(0, 4, 1, 3, 9, 'h33), 9, {63'd0, shadowRegs[1] < shadowRegs[4]});
        addAlu(encR(0, 2, 4, 0, 10, 'h3b), 10, sx32(shadowRegs[4][31:0] + shadowRegs[2][31:0]));
        addAlu(encR(0, 7, 2, 5, 11, 'h3b), 11, sx32(shadowRegs[2][31:0] >> shadowRegs[7][4:0]));
        addAlu(encR('h20, 7, 2, 5, 12, 'h3b), 12,
               sx32($signed(shadowRegs[2][31:0]) >>> shadowRegs[7][4:0]));
        buildTest = 3;
        addAlu(encI(64, 0, 0, 13, 'h13), 13, 64'd64);
        addStore(0, 1, 13, 3);  // sb
        addStore(1, 2, 13, 6);  // sh
        addStore(2, 5, 13, 12); // sw, upper half
        addStore(3, 2, 13, 16); // sd
        addLoad(3, 14, 13, 0);
        addLoad(3, 15, 13, 8);
        buildTest = 4;
        addLoad(0, 16, 13, 3);  // lb
        addLoad(4, 17, 13, 3);  // lbu
        addLoad(1, 18, 13, 26); // lh
        addLoad(6, 19, 13, 28); // lwu
        addLoad(3, 20, 13, 16); // ld
        buildTest = 5;
        addBranches(0, 4, 4, 4, 7); // beq
        addBranches(1, 4, 7, 4, 4); // bne
        addBranches(4, 1, 4, 4, 1); // blt
        addBranches(5, 4, 1, 1, 4); // bge
        addBranches(6, 4, 1, 1, 4); // bltu
        addBranches(7, 1, 4, 4, 1); // bgeu
        buildTest = 6;
        addRow(encJ(8, 21), 21, rowPc(nRows) + 64'd4, 8'h0, 64'd0, 1);
        addPoison();
        addAlu(encU(0, 22, 'h17), 22, rowPc(nRows));
        addRow(encI(13, 22, 0, 23, 'h67), 23, rowPc(nRows) + 64'd4, 8'h0, 64'd0, 1);
        addPoison();
        addRow(encJ(8, 0), 0, 64'd0, 8'h0, 64'd0, 1); // link to x0
        addPoison();
        addAlu(encR(0, 23, 21, 0, 24, 'h33), 24, shadowRegs[21] + shadowRegs[23]);
    endtask

    task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: row %0d %s is %h, expected %h", $time, row, what,
                     got, exp);
            failCount++;
            testErr[curTest]++;
        end
    endtask

    task automatic reportTest(input int t);
        $display("test %0d %s: %0d failed checks", t, testName[t], testErr[t]);
    endtask

    initial begin
        buildProgram();
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        checkValue("instAddr after reset", instAddr, `RESET_PC);
        while (instAddr < rowPc(nRows)) begin
            row = int'(instAddr[8:2]);
            if (rowTest[row] != curTest) begin
                reportTest(curTest);
                curTest = rowTest[row];
            end
            inst = progInst[row];
            @(negedge clk); // mid-cycle, outputs settled
            checkValue("retireValid", 64'(retireValid), 64'(expValid[row]));
            if (expValid[row]) begin
                checkValue("retireRd", 64'(retireRd), 64'(expRd[row]));
                checkValue("retireValue", retireValue, expValue[row]);
            end
            checkValue("dataWmask", 64'(dataWmask), 64'(expMask[row]));
            if (expMask[row] != 8'h0) begin
                checkValue("dataWdata", dataWdata, expWdata[row]);
            end
            checkValue("dataRen", 64'(dataRen), 64'(expRen[row]));
            if (expRen[row] || expMask[row] != 8'h0) begin
                checkValue("dataAddr", dataAddr, expAddr[row]);
            end
            @(posedge clk);
            #1;
            checkValue("next instAddr", instAddr, expNpc[row]);
        end
        inst = 32'h0000_0013;
        reportTest(curTest);
        $display("checks run: %0d, failed: %0d", checkCount, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/rv_pkg.sv
hw/decoder.sv
hw/immGen.sv
hw/alu.sv
hw/regFile.sv
hw/loadStore.sv
hw/pcUnit.sv
hw/rvCore.sv
test/rvCore_sva.sv
test/rvCore_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvCore_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f build.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	cat $(LOG)
	! grep -q "sim failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
